// ==== run_sim.sh ====
#!/bin/sh
# Build the memory stage testbench with Verilator, run it and scan the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f vlog.f --top-module tb_mem_stage -o sim_mem_stage
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/sim_mem_stage > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -qx "Test completed successfully" "$LOG"; then
  echo "PASS"
  exit 0
fi

echo "FAIL"
exit 1

// ==== source/addr_region_decode.sv ====
// Stage 1 request register with region, byte lane and alignment decode
`include "mem_stage_defs.svh"

module addr_region_decode
  import mem_stage_pkg::*;
(
  input  logic   clk_i,
  input  logic   rst_n_i,
  input  logic   req_valid_i,
  input  logic   req_we_i,
  input  size_e  req_size_i,
  input  logic   req_sign_i,
  input  addr_t  req_addr_i,
  input  word_t  req_wdata_i,
  mem_req_if.src out_o
);

  logic     misal;
  logic     periph;
  byte_en_t byte_en;
  word_t    wdata_lane;

  //////////////////////////////
  // Decode
  //////////////////////////////

  always_comb begin
    misal   = 1'b0;
    byte_en = '0;
    case (req_size_i)
      BYTE: begin
        byte_en = byte_en_t'(1) << req_addr_i[1:0];
      end
      HALF_WORD: begin
        // Halfword needs an even address
        misal   = req_addr_i[0];
        byte_en = byte_en_t'(3) << req_addr_i[1:0];
      end
      WORD: begin
        misal   = |req_addr_i[1:0];
        byte_en = '1;
      end
      default: begin
        // Undefined size gets no lanes and reports an error
        misal = 1'b1;
      end
    endcase
    // No lanes at all for a misaligned item, so nothing downstream writes
    if (misal) begin
      byte_en = '0;
    end
  end

  // Move store data up into the addressed lanes
  assign wdata_lane = req_wdata_i << {req_addr_i[1:0], 3'b000};

  // Two regions only, split at the peripheral base
  assign periph = (req_addr_i >= `PERIPH_BASE);

  //////////////////////////////
  // Pipe register
  //////////////////////////////

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      out_o.valid <= 1'b0;
    end else begin
      out_o.valid <= req_valid_i;
    end
  end

  // Payload held when idle
  always_ff @(posedge clk_i) begin
    if (req_valid_i) begin
      out_o.we      <= req_we_i;
      out_o.size    <= req_size_i;
      out_o.sign    <= req_sign_i;
      out_o.addr    <= req_addr_i;
      out_o.wdata   <= wdata_lane;
      out_o.byte_en <= byte_en;
      out_o.periph  <= periph;
      out_o.misal   <= misal;
    end
  end

  // Read data is filled in by the RAM stage
  assign out_o.rdata = '0;

  // Execute side only sends defined access sizes
  a_size_legal: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    req_valid_i |-> req_size_i inside {BYTE, HALF_WORD, WORD});

endmodule

// ==== source/data_ram_bank.sv ====
// Stage 2 byte-enabled data RAM with the peripheral block and read mux
`include "mem_stage_defs.svh"

module data_ram_bank
  import mem_stage_pkg::*;
(
  input  logic   clk_i,
  input  logic   rst_n_i,
  mem_req_if.dst in_i,
  mem_req_if.src out_o,
  input  word_t  gpio_i,
  output word_t  gpio_o
);

  localparam int IDX_W = $clog2(`RAM_WORDS);

  word_t            ram_q [`RAM_WORDS];
  logic [IDX_W-1:0] ram_idx;
  byte_en_t         ram_be;
  logic             per_sel;
  logic             store_done;
  word_t            ram_rdata_q;
  word_t            per_rdata;
  word_t            per_rdata_q;

  //////////////////////////////
  // Region steering
  //////////////////////////////

  // Word index with upper address bits wrapping around the array
  assign ram_idx = in_i.addr[IDX_W+1:2];

  assign per_sel = in_i.valid && in_i.periph;

  // Aligned RAM store that the store counter counts
  assign store_done = in_i.valid && !in_i.periph && in_i.we && !in_i.misal;

  // Lanes written this cycle
  assign ram_be = store_done ? in_i.byte_en : '0;

  //////////////////////////////
  // Data RAM
  //////////////////////////////

  always_ff @(posedge clk_i) begin
    for (int b = 0; b < `BE_W; b++) begin
      if (ram_be[b]) begin
        ram_q[ram_idx][b*8 +: 8] <= in_i.wdata[b*8 +: 8];
      end
    end
    // Read returns old contents on a same-cycle write
    // Store responses ignore the read word
    ram_rdata_q <= ram_q[ram_idx];
  end

  periph_regs u_periph_regs (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .sel_i        (per_sel),
    .we_i         (in_i.we),
    .offset_i     (in_i.addr[`REG_OFF_W-1:0]),
    .byte_en_i    (in_i.byte_en),
    .wdata_i      (in_i.wdata),
    .store_done_i (store_done),
    .rdata_o      (per_rdata),
    .gpio_i       (gpio_i),
    .gpio_o       (gpio_o)
  );

  //////////////////////////////
  // Forward to stage 3
  //////////////////////////////

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      out_o.valid <= 1'b0;
    end else begin
      out_o.valid <= in_i.valid;
    end
  end

  always_ff @(posedge clk_i) begin
    if (in_i.valid) begin
      out_o.we      <= in_i.we;
      out_o.size    <= in_i.size;
      out_o.sign    <= in_i.sign;
      out_o.addr    <= in_i.addr;
      out_o.wdata   <= in_i.wdata;
      out_o.byte_en <= in_i.byte_en;
      out_o.periph  <= in_i.periph;
      out_o.misal   <= in_i.misal;
    end
    // Register value as it was when the item passed
    per_rdata_q <= per_rdata;
  end

  // Pick the source the item went to
  assign out_o.rdata = out_o.periph ? per_rdata_q : ram_rdata_q;

  // A RAM write never comes from an address in the peripheral region
  a_region_excl: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (|ram_be) |-> (in_i.addr < `PERIPH_BASE));

endmodule

// ==== source/load_align.sv ====
// Stage 3 load lane select and extension, response FIFO and writeback credits
`include "mem_stage_defs.svh"

module load_align
  import mem_stage_pkg::*;
(
  input  logic   clk_i,
  input  logic   rst_n_i,
  mem_req_if.dst in_i,
  output logic   rsp_valid_o,
  output word_t  rsp_data_o,
  output logic   rsp_err_o,
  output logic   req_credit_o,
  input  logic   rsp_credit_i
);

  localparam int DEPTH = `REQ_CREDITS;
  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);
  localparam int CRD_W = $clog2(`RSP_CREDITS + 1);

  word_t            lane_word;
  word_t            result;
  logic             push;
  logic             pop;
  word_t            fifo_data_q [DEPTH];
  logic [DEPTH-1:0] fifo_err_q;
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] fill_q;
  logic [CRD_W-1:0] credit_q;

  //////////////////////////////
  // Lane select and extend
  //////////////////////////////

  always_comb begin
    // Addressed byte or halfword down to bit 0
    lane_word = in_i.rdata >> {in_i.addr[1:0], 3'b000};
    result    = '0;
    // Stores and misaligned items answer with zero
    if (!in_i.we && !in_i.misal) begin
      case (in_i.size)
        BYTE: begin
          result = in_i.sign ? {{(`XLEN-8){lane_word[7]}}, lane_word[7:0]}
                             : {{(`XLEN-8){1'b0}}, lane_word[7:0]};
        end
        HALF_WORD: begin
          result = in_i.sign ? {{(`XLEN-16){lane_word[15]}}, lane_word[15:0]}
                             : {{(`XLEN-16){1'b0}}, lane_word[15:0]};
        end
        WORD:    result = lane_word;
        default: result = '0;
      endcase
    end
  end

  //////////////////////////////
  // Response FIFO
  //////////////////////////////

  // Every item gets a slot, no stall upstream
  assign push = in_i.valid;
  // Head leaves only with a writeback credit in hand
  assign pop  = (fill_q != '0) && (credit_q != '0);

  always_ff @(posedge clk_i) begin
    if (push) begin
      fifo_data_q[wr_ptr_q] <= result;
      fifo_err_q[wr_ptr_q]  <= in_i.misal;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      fill_q   <= '0;
      credit_q <= CRD_W'(`RSP_CREDITS);
    end else begin
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      fill_q   <= fill_q + CNT_W'(push) - CNT_W'(pop);
      // Writeback returns one credit per pulse
      credit_q <= credit_q + CRD_W'(rsp_credit_i) - CRD_W'(pop);
    end
  end

  assign rsp_valid_o  = pop;
  assign rsp_data_o   = fifo_data_q[rd_ptr_q];
  assign rsp_err_o    = fifo_err_q[rd_ptr_q];
  // One request credit back per response out
  assign req_credit_o = pop;

  // Upstream credit discipline keeps the FIFO from overflowing
  a_fifo_no_ovf: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    push && (fill_q == CNT_W'(DEPTH)) |-> pop);

  // Writeback never returns more credits than it was given
  a_credit_max: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    credit_q <= CRD_W'(`RSP_CREDITS));

endmodule

// ==== source/mem_req_if.sv ====
// Pipeline item interface between memory-stage pipe registers
interface mem_req_if
  import mem_stage_pkg::*;
();

  // Item present this cycle
  logic     valid;
  // Store when set, load otherwise
  logic     we;
  size_e    size;
  // Sign-extend a narrow load
  logic     sign;
  addr_t    addr;
  // Store data already placed in its byte lanes
  word_t    wdata;
  byte_en_t byte_en;
  // Item targets the peripheral block
  logic     periph;
  // Misaligned halfword or word, no memory effect
  logic     misal;
  // Read word, only meaningful after the RAM stage
  word_t    rdata;

  // Sending stage drives every field
  modport src (
    output valid, we, size, sign, addr, wdata, byte_en, periph, misal, rdata
  );

  // Receiving stage only samples
  modport dst (
    input valid, we, size, sign, addr, wdata, byte_en, periph, misal, rdata
  );

endinterface

// ==== source/mem_stage_defs.svh ====
// Width, address map, RAM depth, register offset and credit count macros
`ifndef MEM_STAGE_DEFS_SVH
`define MEM_STAGE_DEFS_SVH

//////////////////////////////
// Datapath widths
//////////////////////////////

// Machine word width in bits
`define XLEN 32
// Byte lanes per word
`define BE_W (`XLEN / 8)
// Peripheral register offset width, low address bits only
`define REG_OFF_W 8

//////////////////////////////
// Address map
//////////////////////////////

// Data RAM depth in words, power of two
`define RAM_WORDS 64
// Everything at or above this address is peripheral space
`define PERIPH_BASE 32'h0000_1000

// Peripheral register offsets
`define REG_GPIO_OUT 8'h00
`define REG_GPIO_IN 8'h04
`define REG_STORE_CNT 8'h08

// Credits held by the execute side, also the response buffer depth
`define REQ_CREDITS 4
// Credits the stage starts with toward writeback
`define RSP_CREDITS 2

`endif

// ==== source/mem_stage_pkg.sv ====
// Datapath typedefs and the access-size enum for the memory stage
`include "mem_stage_defs.svh"

package mem_stage_pkg;

  //////////////////////////////
  // Datapath vectors
  //////////////////////////////

  // One data word as seen on the load and store path
  typedef logic [`XLEN-1:0] word_t;

  // Byte address from the execute side
  typedef logic [`XLEN-1:0] addr_t;

  // One bit per byte lane of a word
  // Bit 0 is the lowest addressed byte
  typedef logic [`BE_W-1:0] byte_en_t;

  // Offset inside the peripheral register block
  // Upper address bits alias onto the same registers
  typedef logic [`REG_OFF_W-1:0] reg_off_t;

  //////////////////////////////
  // Access size
  //////////////////////////////

  // Encoding of the load/store width
  // Value 3 is unused and treated as illegal
  typedef enum logic [1:0] {
    BYTE      = 2'd0,
    HALF_WORD = 2'd1,
    WORD      = 2'd2
  } size_e;

endpackage

// ==== source/mem_stage_top.sv ====
// Memory stage top: decode, RAM and response stages on two pipe interfaces
module mem_stage_top
  import mem_stage_pkg::*;
(
  input  logic  clk_i,
  input  logic  rst_n_i,
  // Execute side
  input  logic  req_valid_i,
  input  logic  req_we_i,
  input  size_e req_size_i,
  input  logic  req_sign_i,
  input  addr_t req_addr_i,
  input  word_t req_wdata_i,
  output logic  req_credit_o,
  // Writeback side
  output logic  rsp_valid_o,
  output word_t rsp_data_o,
  output logic  rsp_err_o,
  input  logic  rsp_credit_i,
  // GPIO pins
  input  word_t gpio_i,
  output word_t gpio_o
);

  // Stage 1 to stage 2, and stage 2 to stage 3
  mem_req_if s1_s2 ();
  mem_req_if s2_s3 ();

  addr_region_decode u_decode (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .req_valid_i (req_valid_i),
    .req_we_i    (req_we_i),
    .req_size_i  (req_size_i),
    .req_sign_i  (req_sign_i),
    .req_addr_i  (req_addr_i),
    .req_wdata_i (req_wdata_i),
    .out_o       (s1_s2.src)
  );

  data_ram_bank u_ram_bank (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .in_i    (s1_s2.dst),
    .out_o   (s2_s3.src),
    .gpio_i  (gpio_i),
    .gpio_o  (gpio_o)
  );

  load_align u_load_align (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .in_i         (s2_s3.dst),
    .rsp_valid_o  (rsp_valid_o),
    .rsp_data_o   (rsp_data_o),
    .rsp_err_o    (rsp_err_o),
    .req_credit_o (req_credit_o),
    .rsp_credit_i (rsp_credit_i)
  );

endmodule

// ==== source/periph_regs.sv ====
// Peripheral registers: GPIO output, sampled GPIO input and RAM store count
`include "mem_stage_defs.svh"

module periph_regs
  import mem_stage_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_n_i,
  input  logic     sel_i,
  input  logic     we_i,
  input  reg_off_t offset_i,
  input  byte_en_t byte_en_i,
  input  word_t    wdata_i,
  input  logic     store_done_i,
  output word_t    rdata_o,
  input  word_t    gpio_i,
  output word_t    gpio_o
);

  word_t gpio_out_q;
  word_t gpio_in_q;
  word_t store_cnt_q;
  logic  out_wr;

  // Misaligned items arrive with no lanes, so they write nothing
  assign out_wr = sel_i && we_i && (offset_i == reg_off_t'(`REG_GPIO_OUT));

  //////////////////////////////
  // Registers
  //////////////////////////////

  // GPIO out, byte-enabled writes
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      gpio_out_q <= '0;
    end else if (out_wr) begin
      for (int b = 0; b < `BE_W; b++) begin
        if (byte_en_i[b]) begin
          gpio_out_q[b*8 +: 8] <= wdata_i[b*8 +: 8];
        end
      end
    end
  end

  // Pins sampled every cycle, count bumps once per aligned RAM store
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      gpio_in_q   <= '0;
      store_cnt_q <= '0;
    end else begin
      gpio_in_q <= gpio_i;
      if (store_done_i) begin
        store_cnt_q <= store_cnt_q + 1'b1;
      end
    end
  end

  assign gpio_o = gpio_out_q;

  // Read mux, unmapped offsets read zero
  always_comb begin
    case (offset_i)
      reg_off_t'(`REG_GPIO_OUT):  rdata_o = gpio_out_q;
      reg_off_t'(`REG_GPIO_IN):   rdata_o = gpio_in_q;
      reg_off_t'(`REG_STORE_CNT): rdata_o = store_cnt_q;
      default:                    rdata_o = '0;
    endcase
  end

endmodule

// ==== tb/mem_stage_vectors.svh ====
// Stimulus table: request fields with expected response data and error flag
`ifndef MEM_STAGE_VECTORS_SVH
`define MEM_STAGE_VECTORS_SVH

  // Appends one table row
  task automatic add_vec(input string name, input logic we, input size_e acc_size,
                         input logic sign, input addr_t addr, input word_t wdata,
                         input word_t exp_data, input logic exp_err);
    vec_t v;
    v.we       = we;
    v.acc_size = acc_size;
    v.sign     = sign;
    v.addr     = addr;
    v.wdata    = wdata;
    v.exp_data = exp_data;
    v.exp_err  = exp_err;
    v.hold     = tbl_hold;
    vecs.push_back(v);
    vec_names.push_back(name);
  endtask

  task automatic load_vectors();
    // name, we, size, sign, addr, wdata, expected data, expected error
    // Word store and load back
    add_vec("st_w0",     1'b1, WORD,      1'b0, 32'h00000000, 32'h876543A1, 32'h0, 1'b0);
    add_vec("st_w1",     1'b1, WORD,      1'b0, 32'h00000004, 32'h12345678, 32'h0, 1'b0);
    add_vec("ld_w0",     1'b0, WORD,      1'b0, 32'h00000000, 32'h0, 32'h876543A1, 1'b0);
    add_vec("ld_w1",     1'b0, WORD,      1'b0, 32'h00000004, 32'h0, 32'h12345678, 1'b0);
    // Narrow loads from word 0, lanes A1 43 65 87
    add_vec("ld_b0_s",   1'b0, BYTE,      1'b1, 32'h00000000, 32'h0, 32'hFFFFFFA1, 1'b0);
    add_vec("ld_b0_u",   1'b0, BYTE,      1'b0, 32'h00000000, 32'h0, 32'h000000A1, 1'b0);
    add_vec("ld_b1_s",   1'b0, BYTE,      1'b1, 32'h00000001, 32'h0, 32'h00000043, 1'b0);
    add_vec("ld_b3_s",   1'b0, BYTE,      1'b1, 32'h00000003, 32'h0, 32'hFFFFFF87, 1'b0);
    add_vec("ld_h0_s",   1'b0, HALF_WORD, 1'b1, 32'h00000000, 32'h0, 32'h000043A1, 1'b0);
    add_vec("ld_h2_s",   1'b0, HALF_WORD, 1'b1, 32'h00000002, 32'h0, 32'hFFFF8765, 1'b0);
    add_vec("ld_h2_u",   1'b0, HALF_WORD, 1'b0, 32'h00000002, 32'h0, 32'h00008765, 1'b0);
    // Narrow stores into word 1
    add_vec("st_b5",     1'b1, BYTE,      1'b0, 32'h00000005, 32'h000000EE, 32'h0, 1'b0);
    add_vec("ld_w1_b",   1'b0, WORD,      1'b0, 32'h00000004, 32'h0, 32'h1234EE78, 1'b0);
    add_vec("st_h6",     1'b1, HALF_WORD, 1'b0, 32'h00000006, 32'h0000BEEF, 32'h0, 1'b0);
    add_vec("ld_w1_h",   1'b0, WORD,      1'b0, 32'h00000004, 32'h0, 32'hBEEFEE78, 1'b0);
    // Misaligned, no memory effect
    add_vec("st_h_mis",  1'b1, HALF_WORD, 1'b0, 32'h00000001, 32'hFFFFFFFF, 32'h0, 1'b1);
    add_vec("ld_w_mis",  1'b0, WORD,      1'b0, 32'h00000002, 32'h0, 32'h0, 1'b1);
    add_vec("st_w_mis",  1'b1, WORD,      1'b0, 32'h00000006, 32'h0, 32'h0, 1'b1);
    add_vec("ld_w0_chk", 1'b0, WORD,      1'b0, 32'h00000000, 32'h0, 32'h876543A1, 1'b0);
    add_vec("ld_w1_chk", 1'b0, WORD,      1'b0, 32'h00000004, 32'h0, 32'hBEEFEE78, 1'b0);
    // Back-pressure rows, writeback credits withheld
    tbl_hold = 1'b1;
    add_vec("bp_ld_w0",  1'b0, WORD,      1'b0, 32'h00000000, 32'h0, 32'h876543A1, 1'b0);
    add_vec("bp_st_w2",  1'b1, WORD,      1'b0, 32'h00000008, 32'h0BADF00D, 32'h0, 1'b0);
    add_vec("bp_ld_w2",  1'b0, WORD,      1'b0, 32'h00000008, 32'h0, 32'h0BADF00D, 1'b0);
    add_vec("bp_ld_b5",  1'b0, BYTE,      1'b0, 32'h00000005, 32'h0, 32'h000000EE, 1'b0);
    tbl_hold = 1'b0;
    // Peripheral block
    add_vec("gpio_wr_w", 1'b1, WORD,      1'b0, 32'h00001000, 32'h11223344, 32'h0, 1'b0);
    add_vec("gpio_wr_b", 1'b1, BYTE,      1'b0, 32'h00001000, 32'h000000A5, 32'h0, 1'b0);
    add_vec("gpio_wr_h", 1'b1, HALF_WORD, 1'b0, 32'h00001000, 32'h0000C3D4, 32'h0, 1'b0);
    add_vec("gpio_rd",   1'b0, WORD,      1'b0, 32'h00001000, 32'h0, 32'h1122C3D4, 1'b0);
    add_vec("gpio_rd_b", 1'b0, BYTE,      1'b1, 32'h00001000, 32'h0, 32'hFFFFFFD4, 1'b0);
    add_vec("gpio_in",   1'b0, WORD,      1'b0, 32'h00001004, 32'h0, GPIO_IN_VAL, 1'b0);
    // Five aligned RAM stores so far
    add_vec("st_cnt_rd", 1'b0, WORD,      1'b0, 32'h00001008, 32'h0, 32'h00000005, 1'b0);
    add_vec("unmap_rd",  1'b0, WORD,      1'b0, 32'h0000100C, 32'h0, 32'h0, 1'b0);
  endtask

`endif

// ==== tb/tb_mem_stage.sv ====
// Memory stage testbench: clock, reset, credit-aware driver, checker and watchdog
`include "mem_stage_defs.svh"

module tb_mem_stage
  import mem_stage_pkg::*;
();

  // Inputs change this long after the rising edge
  localparam int    DRV_DLY      = 2;
  // Cycles for held responses to settle in the back-pressure phase
  localparam int    SETTLE_CYC   = 8;
  localparam word_t GPIO_IN_VAL  = 32'h5EED_0007;
  // Last GPIO out value the table writes
  localparam word_t GPIO_OUT_EXP = 32'h1122_C3D4;

  typedef struct packed {
    logic  we;
    size_e acc_size;
    logic  sign;
    addr_t addr;
    word_t wdata;
    word_t exp_data;
    logic  exp_err;
    logic  hold;
  } vec_t;

  logic  clk_i = 1'b0;
  logic  rst_n_i;
  logic  req_valid_i;
  logic  req_we_i;
  size_e req_size_i;
  logic  req_sign_i;
  addr_t req_addr_i;
  word_t req_wdata_i;
  logic  req_credit_o;
  logic  rsp_valid_o;
  word_t rsp_data_o;
  logic  rsp_err_o;
  logic  rsp_credit_i;
  word_t gpio_i;
  word_t gpio_o;

  vec_t  vecs [$];
  string vec_names [$];
  logic  tbl_hold = 1'b0;
  int    num_vec = 0;
  // Driver side
  int    issued = 0;
  logic  holding = 1'b0;
  int    drv_errs = 0;
  // Checker side
  int    rsp_cnt = 0;
  int    hold_rsp_cnt = 0;
  int    value_errs = 0;
  int    seq_errs = 0;
  // Execute-side credit view
  int    req_credits = `REQ_CREDITS;
  int    proto_errs = 0;
  // Writeback credits handed back
  int    credits_back = 0;

  `include "mem_stage_vectors.svh"

  mem_stage_top mem_stage_top_i (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .req_valid_i  (req_valid_i),
    .req_we_i     (req_we_i),
    .req_size_i   (req_size_i),
    .req_sign_i   (req_sign_i),
    .req_addr_i   (req_addr_i),
    .req_wdata_i  (req_wdata_i),
    .req_credit_o (req_credit_o),
    .rsp_valid_o  (rsp_valid_o),
    .rsp_data_o   (rsp_data_o),
    .rsp_err_o    (rsp_err_o),
    .rsp_credit_i (rsp_credit_i),
    .gpio_i       (gpio_i),
    .gpio_o       (gpio_o)
  );

  always #20 clk_i = ~clk_i;

  //////////////////////////////
  // Driver helpers
  //////////////////////////////

  // Sends one row once a request credit is in hand
  task automatic issue(input int k);
    while (req_credits == 0) begin
      @(posedge clk_i);
      #DRV_DLY;
    end
    req_valid_i = 1'b1;
    req_we_i    = vecs[k].we;
    req_size_i  = vecs[k].acc_size;
    req_sign_i  = vecs[k].sign;
    req_addr_i  = vecs[k].addr;
    req_wdata_i = vecs[k].wdata;
    issued++;
    @(posedge clk_i);
    #DRV_DLY;
    req_valid_i = 1'b0;
  endtask

  // Returns one unit after an edge, once all responses are in and credits returned
  task automatic wait_drained();
    logic done;
    done = 1'b0;
    while (!done) begin
      @(posedge clk_i);
      #1;
      done = (rsp_cnt == issued) && (credits_back == rsp_cnt) && !rsp_credit_i;
    end
  endtask

  // Ends the back-pressure phase after the pipeline settles
  task automatic release_hold();
    repeat (SETTLE_CYC) @(posedge clk_i);
    #1;
    if (hold_rsp_cnt > `RSP_CREDITS) begin
      drv_errs++;
      $display("%0d responses left with only %0d writeback credits",
               hold_rsp_cnt, `RSP_CREDITS);
    end
    holding = 1'b0;
    #(DRV_DLY - 1);
  endtask

  // Compares one response with its table row
  task automatic check_rsp(input int k);
    if (rsp_data_o !== vecs[k].exp_data) begin
      value_errs++;
      $display("[ERROR] %s data: expected %h, actual %h",
               vec_names[k], vecs[k].exp_data, rsp_data_o);
    end
    if (rsp_err_o !== vecs[k].exp_err) begin
      value_errs++;
      $display("[ERROR] %s err: expected %b, actual %b",
               vec_names[k], vecs[k].exp_err, rsp_err_o);
    end
  endtask

  //////////////////////////////
  // Stimulus
  //////////////////////////////

  initial begin
    void'($urandom(7));
    rst_n_i     = 1'b0;
    req_valid_i = 1'b0;
    req_we_i    = 1'b0;
    req_size_i  = WORD;
    req_sign_i  = 1'b0;
    req_addr_i  = '0;
    req_wdata_i = '0;
    gpio_i      = GPIO_IN_VAL;
    load_vectors();
    num_vec = vecs.size();
    repeat (5) @(posedge clk_i);
    #DRV_DLY;
    rst_n_i = 1'b1;
    for (int i = 0; i < num_vec; i++) begin
      // Entering back-pressure with an empty pipe and full writeback credits
      if (vecs[i].hold && !holding) begin
        wait_drained();
        holding = 1'b1;
        #(DRV_DLY - 1);
      end
      if (!vecs[i].hold && holding) begin
        release_hold();
      end
      // Random idle gap between requests
      repeat ($urandom_range(2)) begin
        @(posedge clk_i);
        #DRV_DLY;
      end
      issue(i);
    end
    if (holding) begin
      release_hold();
    end
    wait_drained();
    if (gpio_o !== GPIO_OUT_EXP) begin
      drv_errs++;
      $display("[ERROR] gpio_o: expected %h, actual %h", GPIO_OUT_EXP, gpio_o);
    end
    $display("Errors: %0d value, %0d credit, %0d order, %0d phase; %0d responses",
             value_errs, proto_errs, seq_errs, drv_errs, rsp_cnt);
    if (value_errs + proto_errs + seq_errs + drv_errs == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

  //////////////////////////////
  // Monitors
  //////////////////////////////

  // Request credit ledger, sampled mid-cycle
  always @(negedge clk_i) begin
    if (rst_n_i) begin
      if (req_valid_i) begin
        if (req_credits == 0) begin
          proto_errs++;
          $display("Request issued without a credit at time %0t", $time);
        end
        req_credits--;
      end
      if (req_credit_o) begin
        req_credits++;
      end
      if (req_credits > `REQ_CREDITS) begin
        proto_errs++;
        $display("Request credit returned with nothing outstanding at time %0t", $time);
      end
    end
  end

  // Responses arrive in table order
  always @(negedge clk_i) begin
    if (rst_n_i && rsp_valid_o) begin
      if (rsp_cnt >= issued) begin
        seq_errs++;
        $display("Response with no request outstanding at time %0t", $time);
      end else begin
        check_rsp(rsp_cnt);
      end
      rsp_cnt++;
      if (holding) begin
        hold_rsp_cnt++;
      end
    end
  end

  // Writeback returns a credit the cycle after each response unless held
  initial begin
    rsp_credit_i = 1'b0;
    forever begin
      @(posedge clk_i);
      #DRV_DLY;
      if (!holding && credits_back < rsp_cnt) begin
        rsp_credit_i = 1'b1;
        credits_back++;
      end else begin
        rsp_credit_i = 1'b0;
      end
    end
  end

  // Watchdog scaled by table length
  initial begin
    wait (num_vec != 0);
    repeat (num_vec * 20 + 200) @(posedge clk_i);
    $display("Watchdog timeout with %0d of %0d responses received", rsp_cnt, num_vec);
    $display("Test failed");
    $finish;
  end

endmodule

// ==== vlog.f ====
+incdir+source
+incdir+tb
source/mem_stage_pkg.sv
source/mem_req_if.sv
source/addr_region_decode.sv
source/periph_regs.sv
source/data_ram_bank.sv
source/load_align.sv
source/mem_stage_top.sv
tb/tb_mem_stage.sv
